/* hw/lsu_pkg.sv */
// Fixed 32-bit data path and a depth of two; data type code 3 decodes as a word
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////

  localparam int DATA_W    = 32;              // Data and address width
  localparam int BE_W      = DATA_W / 8;      // One enable per byte lane
  localparam int OFFS_W    = 2;               // Byte offset within a word

  // Outstanding transaction limit and its counter width
  localparam int LSU_DEPTH = 2;
  localparam int CNT_W     = 2;               // Must hold LSU_DEPTH itself

  ////////////////////////////////////////////////////////////////////
  // Data type codes
  ////////////////////////////////////////////////////////////////////

  localparam logic [1:0] DT_BYTE = 2'd0;
  localparam logic [1:0] DT_HALF = 2'd1;
  localparam logic [1:0] DT_WORD = 2'd2;      // Code 3 falls back to word

  // One memory word, seen as byte lanes or as halfwords
  // Lane 0 is the least significant byte in both views
  typedef union packed {
    logic [BE_W-1:0][7:0]   b;                // Byte lanes
    logic [BE_W/2-1:0][15:0] h;               // Halfword lanes
  } lsu_word_u;

endpackage : lsu_pkg

`default_nettype wire

/* hw/lsu_ctrl.sv */
// Responses must come in order and at least one cycle after their grant; no error path
`default_nettype none

module lsu_ctrl import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  input  logic data_req_i,                    // EX stage wants a transfer
  input  logic mem_gnt_i,                     // Memory accepts the request
  input  logic mem_rvalid_i,                  // Response for oldest transfer

  output logic trans_valid_o,                 // Request towards memory
  output logic ready_ex_o,                    // EX may advance
  output logic ready_wb_o,                    // WB may advance
  output logic wb_update_o,                   // Load WB control registers
  output logic busy_o
);

  logic [CNT_W-1:0] cnt_q;                    // Outstanding transfers
  logic [CNT_W-1:0] next_cnt;
  logic             count_up;                 // Accepted request
  logic             count_down;               // Received response

  ////////////////////////////////////////////////////////////////////
  // Request gating and readiness
  ////////////////////////////////////////////////////////////////////

  // Never issue once the limit is reached
  assign trans_valid_o = data_req_i && (cnt_q < CNT_W'(LSU_DEPTH));

  // WB free when empty, else only as its response arrives
  assign ready_wb_o = (cnt_q == '0) ? 1'b1 : mem_rvalid_i;

  // EX and WB move in lock step once WB holds a transfer
  always_comb
  begin
    if (!data_req_i)
      ready_ex_o = 1'b1;                      // Nothing to do in EX
    else if (cnt_q == CNT_W'(0))
      ready_ex_o = trans_valid_o && mem_gnt_i;
    else if (cnt_q == CNT_W'(1))
      ready_ex_o = mem_rvalid_i && trans_valid_o && mem_gnt_i;
    else
      ready_ex_o = mem_rvalid_i;              // Full, wait for a slot
  end

  assign wb_update_o = ready_ex_o && data_req_i;

  // Busy while anything is in flight or about to be
  assign busy_o = (cnt_q != '0) || trans_valid_o;

  ////////////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////////////

  assign count_up   = trans_valid_o && mem_gnt_i;
  assign count_down = mem_rvalid_i;

  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   next_cnt = cnt_q + CNT_W'(1);
      2'b01:   next_cnt = cnt_q - CNT_W'(1);
      default: next_cnt = cnt_q;              // Idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q <= '0;
    end
    else
    begin
      cnt_q <= next_cnt;
    end
  end

endmodule : lsu_ctrl

`default_nettype wire

/* hw/lsu_wr_align.sv */
// Purely combinational; second phase of a split access comes from the core with data_misaligned_i
`default_nettype none

module lsu_wr_align import lsu_pkg::*;
(
  input  logic              data_req_i,
  input  logic [1:0]        data_type_i,        // Byte, half or word
  input  logic              data_misaligned_i,  // Second phase of a split access
  input  logic              prepost_useincr_i,  // Add operand b
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  input  logic [DATA_W-1:0] wdata_i,            // Store data, LSB aligned

  output logic [DATA_W-1:0] addr_o,
  output logic [BE_W-1:0]   be_o,
  output logic [DATA_W-1:0] wdata_o,
  output logic [OFFS_W-1:0] addr_offs_o,        // Byte offset for the read path
  output logic              misaligned_o        // First phase needs a second one
);

  logic [DATA_W-1:0] addr_int;                  // Unaligned effective address
  logic [OFFS_W-1:0] addr_offs;
  lsu_word_u         wdata_src;
  lsu_word_u         wdata_rot;

  ////////////////////////////////////////////////////////////////////
  // Address
  ////////////////////////////////////////////////////////////////////

  assign addr_int  = prepost_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_offs = addr_int[OFFS_W-1:0];

  // Second phase always starts at the word boundary
  assign addr_o      = data_misaligned_i ? {addr_int[DATA_W-1:OFFS_W], {OFFS_W{1'b0}}}
                                         : addr_int;
  assign addr_offs_o = addr_offs;

  ////////////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (data_type_i)
      DT_BYTE:
      begin
        be_o = BE_W'(1) << addr_offs;           // Single lane
      end
      DT_HALF:
      begin
        if (data_misaligned_i)
          be_o = 4'b0001;                       // Upper byte spills into next word
        else
        begin
          case (addr_offs)
            2'd0:    be_o = 4'b0011;
            2'd1:    be_o = 4'b0110;
            2'd2:    be_o = 4'b1100;
            default: be_o = 4'b1000;            // Lower byte only, rest in phase two
          endcase
        end
      end
      default:
      begin
        // Word, phase one covers the top lanes and phase two the rest
        case ({data_misaligned_i, addr_offs})
          3'b000:  be_o = 4'b1111;
          3'b001:  be_o = 4'b1110;
          3'b010:  be_o = 4'b1100;
          3'b011:  be_o = 4'b1000;
          3'b101:  be_o = 4'b0001;
          3'b110:  be_o = 4'b0011;
          3'b111:  be_o = 4'b0111;
          default: be_o = 4'b0000;              // Aligned word has no second phase
        endcase
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Store data rotation
  ////////////////////////////////////////////////////////////////////

  assign wdata_src = wdata_i;

  // Rotate left by the offset, lane i takes source lane i - offs
  always_comb
  begin
    for (int i = 0; i < BE_W; i++)
    begin
      wdata_rot.b[i] = wdata_src.b[OFFS_W'(i) - addr_offs];
    end
  end

  assign wdata_o = wdata_rot;

  // Split detection, only on a first phase
  always_comb
  begin
    misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_i)
    begin
      case (data_type_i)
        DT_BYTE: misaligned_o = 1'b0;           // Bytes never cross a word
        DT_HALF: misaligned_o = (addr_offs == 2'd3);
        default: misaligned_o = (addr_offs != 2'd0);
      endcase
    end
  end

endmodule : lsu_wr_align

`default_nettype wire

/* hw/lsu_rd_align.sv */
// Load result valid only in the rvalid cycle or from the held copy; one split load at a time
`default_nettype none

module lsu_rd_align import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              wb_update_i,        // Transfer moves into WB
  input  logic [1:0]        data_type_i,
  input  logic              data_sign_ext_i,
  input  logic              data_we_i,
  input  logic [OFFS_W-1:0] addr_offs_i,
  input  logic              data_misaligned_i,  // Second phase in EX
  input  logic              misaligned_i,       // First phase of a split in EX

  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i,

  output logic [DATA_W-1:0] rdata_o             // To register file
);

  // WB control, captured with the request
  logic [1:0]        data_type_q;
  logic [OFFS_W-1:0] rdata_offs_q;
  logic              sign_ext_q;
  logic              we_q;

  logic [DATA_W-1:0] rdata_q;                   // Held result or first half
  lsu_word_u         resp_w;
  lsu_word_u         held_w;

  logic [15:0]       half_sel;
  logic [7:0]        byte_sel;
  logic [DATA_W-1:0] rdata_w_ext;
  logic [DATA_W-1:0] rdata_h_ext;
  logic [DATA_W-1:0] rdata_b_ext;
  logic [DATA_W-1:0] rdata_ext;

  // Extension helpers, sgn low gives zero extension
  function automatic logic [DATA_W-1:0] ext16(input logic [15:0] val, input logic sgn);
    return {{(DATA_W-16){sgn & val[15]}}, val};
  endfunction

  function automatic logic [DATA_W-1:0] ext8(input logic [7:0] val, input logic sgn);
    return {{(DATA_W-8){sgn & val[7]}}, val};
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_type_q  <= DT_BYTE;
      rdata_offs_q <= '0;
      sign_ext_q   <= 1'b0;
      we_q         <= 1'b0;
    end
    else if (wb_update_i)                       // Granted, response still to come
    begin
      data_type_q  <= data_type_i;
      rdata_offs_q <= addr_offs_i;
      sign_ext_q   <= data_sign_ext_i;
      we_q         <= data_we_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Field selection and extension
  ////////////////////////////////////////////////////////////////////

  assign resp_w = mem_rdata_i;
  assign held_w = rdata_q;

  // Split word, low lanes come from the held first response
  always_comb
  begin
    case (rdata_offs_q)
      2'd0:    rdata_w_ext = resp_w;
      2'd1:    rdata_w_ext = {resp_w.b[0], held_w.b[3], held_w.b[2], held_w.b[1]};
      2'd2:    rdata_w_ext = {resp_w.h[0], held_w.h[1]};
      default: rdata_w_ext = {resp_w.b[2], resp_w.b[1], resp_w.b[0], held_w.b[3]};
    endcase
  end

  always_comb
  begin
    case (rdata_offs_q)
      2'd0:    half_sel = resp_w.h[0];
      2'd1:    half_sel = {resp_w.b[2], resp_w.b[1]};
      2'd2:    half_sel = resp_w.h[1];
      default: half_sel = {resp_w.b[0], held_w.b[3]};  // Crosses into next word
    endcase
  end

  assign byte_sel    = resp_w.b[rdata_offs_q];
  assign rdata_h_ext = ext16(half_sel, sign_ext_q);
  assign rdata_b_ext = ext8(byte_sel, sign_ext_q);

  always_comb
  begin
    case (data_type_q)
      DT_BYTE: rdata_ext = rdata_b_ext;
      DT_HALF: rdata_ext = rdata_h_ext;
      default: rdata_ext = rdata_w_ext;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Held data
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata_q <= '0;
    end
    else if (mem_rvalid_i && !we_q)
    begin
      // Raw word while a split is in progress, final value otherwise
      if (data_misaligned_i || misaligned_i)
        rdata_q <= mem_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign rdata_o = mem_rvalid_i ? rdata_ext : rdata_q;

endmodule : lsu_rd_align

`default_nettype wire

/* hw/lsu_top.sv */
// At most two transfers in flight; the core controller must issue the second phase of split accesses
`default_nettype none

module lsu_top import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // EX stage request
  input  logic              data_req_i,
  input  logic              data_we_i,
  input  logic [1:0]        data_type_i,
  input  logic              data_sign_ext_i,
  input  logic              data_misaligned_i,
  input  logic              prepost_useincr_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  input  logic [DATA_W-1:0] wdata_i,

  // Memory side
  output logic              mem_req_o,
  input  logic              mem_gnt_i,
  output logic [DATA_W-1:0] mem_addr_o,
  output logic              mem_we_o,
  output logic [BE_W-1:0]   mem_be_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i,

  // To the core
  output logic [DATA_W-1:0] lsu_rdata_o,
  output logic              lsu_misaligned_o,
  output logic              lsu_ready_ex_o,
  output logic              lsu_ready_wb_o,
  output logic              busy_o
);

  logic              trans_valid;
  logic              wb_update;
  logic [OFFS_W-1:0] addr_offs;

  assign mem_req_o = trans_valid;
  assign mem_we_o  = data_we_i;                 // Write flag passes straight out

  lsu_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_req_i    (data_req_i),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .trans_valid_o (trans_valid),
    .ready_ex_o    (lsu_ready_ex_o),
    .ready_wb_o    (lsu_ready_wb_o),
    .wb_update_o   (wb_update),
    .busy_o        (busy_o)
  );

  lsu_wr_align u_wr_align (
    .data_req_i        (data_req_i),
    .data_type_i       (data_type_i),
    .data_misaligned_i (data_misaligned_i),
    .prepost_useincr_i (prepost_useincr_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .wdata_i           (wdata_i),
    .addr_o            (mem_addr_o),
    .be_o              (mem_be_o),
    .wdata_o           (mem_wdata_o),
    .addr_offs_o       (addr_offs),
    .misaligned_o      (lsu_misaligned_o)
  );

  lsu_rd_align u_rd_align (
    .clk               (clk),
    .rst_n             (rst_n),
    .wb_update_i       (wb_update),
    .data_type_i       (data_type_i),
    .data_sign_ext_i   (data_sign_ext_i),
    .data_we_i         (data_we_i),
    .addr_offs_i       (addr_offs),
    .data_misaligned_i (data_misaligned_i),
    .misaligned_i      (lsu_misaligned_o),
    .mem_rvalid_i      (mem_rvalid_i),
    .mem_rdata_i       (mem_rdata_i),
    .rdata_o           (lsu_rdata_o)
  );

endmodule : lsu_top

`default_nettype wire

/* tb/tb_clkgen.sv */
// Free-running 8 ns clock; reset held low for the first 16 rising edges
`default_nettype none

module tb_clkgen
(
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;                    // 8 ns period
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;                            // Release on an edge like other inputs
  end

endmodule : tb_clkgen

`default_nettype wire

/* tb/lsu_sva.sv */
// Bound into lsu_ctrl; checks counter range, stray responses and busy, only outside reset
`default_nettype none

module lsu_sva import lsu_pkg::*;
(
  input logic             clk,
  input logic             rst_n,
  input logic [CNT_W-1:0] cnt_q,
  input logic             mem_rvalid_i,
  input logic             busy_o
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////////////
  // Outstanding transfer properties
  ////////////////////////////////////////////////////////////////////

  // Request gating keeps the count within the depth
  a_depth: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_W'(LSU_DEPTH))
    else $error("outstanding count above depth");

  // Every response belongs to an accepted transfer
  a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rvalid_i |-> (cnt_q != '0))
    else $error("response with nothing outstanding");

  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q != '0) |-> busy_o)
    else $error("busy low with transfers in flight");

endmodule : lsu_sva

`default_nettype wire

/* tb/lsu_tb.sv */
// Directed tests for lsu_top; memory model grants at once and answers after resp_delay cycles
`default_nettype none

module lsu_tb import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 2000;           // About 300 cycles of tests plus margin
  localparam int N_RAND     = 24;

  logic        clk;
  logic        rst_n;
  logic        data_req_i;
  logic        data_we_i;
  logic [1:0]  data_type_i;
  logic        data_sign_ext_i;
  logic        data_misaligned_i;
  logic        prepost_useincr_i;
  logic [31:0] operand_a_i;
  logic [31:0] operand_b_i;
  logic [31:0] wdata_i;
  logic        mem_req_o;
  logic        mem_gnt_i;
  logic [31:0] mem_addr_o;
  logic        mem_we_o;
  logic [3:0]  mem_be_o;
  logic [31:0] mem_wdata_o;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  logic [31:0] lsu_rdata_o;
  logic        lsu_misaligned_o;
  logic        lsu_ready_ex_o;
  logic        lsu_ready_wb_o;
  logic        busy_o;

  // Memory model, word addressed, untouched words come from fill_word
  logic [31:0] mem [logic [29:0]];
  logic [31:0] rsp_data_q[$];                 // Read data captured at grant
  int          rsp_cyc_q[$];                  // Grant cycle of each entry
  int          resp_delay;
  int          cycles;
  logic [29:0] rsp_wa;
  logic [31:0] rsp_w;

  int checks;
  int errors;
  int tests;

  tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

  lsu_top uut (.*);

  bind lsu_ctrl lsu_sva u_sva (
    .clk(clk), .rst_n(rst_n), .cnt_q(cnt_q), .mem_rvalid_i(mem_rvalid_i), .busy_o(busy_o)
  );

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] fill_word(input logic [29:0] wa);
    return (32'(wa) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;   // Every address bit matters
  endfunction

  function automatic logic [31:0] read_word(input logic [29:0] wa);
    if (mem.exists(wa))
      return mem[wa];
    return fill_word(wa);
  endfunction

  // Phase one takes lanes from offs upward, phase two the lanes below offs
  function automatic logic [3:0] exp_be(input logic [1:0] typ, input int offs, input bit ph2);
    logic [7:0] m;
    if (typ == DT_BYTE)
      m = 8'h01 << offs;
    else if (typ == DT_HALF)
      m = 8'h03 << offs;
    else
      m = 8'h0f << offs;
    return ph2 ? m[7:4] : m[3:0];
  endfunction

  function automatic logic [31:0] rotl_bytes(input logic [31:0] d, input int offs);
    if (offs == 0)
      return d;
    return (d << (8 * offs)) | (d >> (32 - 8 * offs));
  endfunction

  function automatic logic [31:0] exp_load(input logic [31:0] w, input logic [1:0] typ,
                                           input int offs, input bit sext);
    logic [31:0] s;
    s = w >> (8 * offs);
    if (typ == DT_BYTE)
      return {{24{sext & s[7]}}, s[7:0]};
    else if (typ == DT_HALF)
      return {{16{sext & s[15]}}, s[15:0]};
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Cycle limit and memory responder
  ////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
    else
    begin
      mem_rvalid_i <= 1'b0;
      if (rsp_data_q.size() > 0 && (cycles - rsp_cyc_q[0]) >= resp_delay)
      begin
        mem_rvalid_i <= 1'b1;                 // Oldest first, one per cycle
        mem_rdata_i  <= rsp_data_q.pop_front();
        void'(rsp_cyc_q.pop_front());
      end
      if (rst_n && mem_req_o && mem_gnt_i)
      begin
        rsp_wa = mem_addr_o[31:2];
        rsp_w  = read_word(rsp_wa);
        rsp_data_q.push_back(rsp_w);
        rsp_cyc_q.push_back(cycles);
        if (mem_we_o)
        begin
          for (int b = 0; b < 4; b++)
            if (mem_be_o[b])
              rsp_w[8*b +: 8] = mem_wdata_o[8*b +: 8];
          mem[rsp_wa] = rsp_w;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic drive(input bit we, input logic [1:0] typ, input bit sext, input bit mis,
                       input logic [31:0] a, input logic [31:0] b, input logic [31:0] wd);
    data_req_i        <= 1'b1;
    data_we_i         <= we;
    data_type_i       <= typ;
    data_sign_ext_i   <= sext;
    data_misaligned_i <= mis;
    prepost_useincr_i <= 1'b1;
    operand_a_i       <= a;
    operand_b_i       <= b;
    wdata_i           <= wd;
  endtask

  task automatic release_req();
    data_req_i        <= 1'b0;
    data_we_i         <= 1'b0;
    data_misaligned_i <= 1'b0;
  endtask

  // All waits sample at the edge, before this edge's updates
  task automatic wait_grant();
    @(posedge clk);
    while (!(mem_req_o && mem_gnt_i))
      @(posedge clk);
  endtask

  task automatic wait_rvalid();
    @(posedge clk);
    while (!mem_rvalid_i)
      @(posedge clk);
  endtask

  task automatic wait_idle();
    @(posedge clk);
    while (busy_o)
      @(posedge clk);
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    tests++;
    $display("%-26s checks %0d errors %0d", name, checks - c0, errors - e0);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////

  task automatic aligned_stores();
    int c0;
    int e0;
    logic [31:0] base;
    logic [31:0] wd;
    c0   = checks;
    e0   = errors;
    base = 32'h0000_0100;
    for (int t = 0; t < 3; t++)
    begin
      for (int o = 0; o < 4; o++)
      begin
        if ((t == 1 && o == 3) || (t == 2 && o != 0))
          continue;                           // Those split, see later tests
        wd = $urandom;
        @(posedge clk);
        drive(1'b1, 2'(t), 1'b0, 1'b0, base, 32'(o), wd);
        wait_grant();
        compare("mem_be_o", 32'(mem_be_o), 32'(exp_be(2'(t), o, 1'b0)));
        compare("mem_wdata_o", mem_wdata_o, rotl_bytes(wd, o));
        compare("mem_addr_o", mem_addr_o, base + 32'(o));
        compare("mem_we_o", 32'(mem_we_o), 32'd1);
        release_req();
        wait_idle();
        base = base + 32'd16;
      end
    end
    report_test("aligned stores", c0, e0);
  endtask

  task automatic byte_half_loads();
    int c0;
    int e0;
    logic [31:0] base;
    c0   = checks;
    e0   = errors;
    base = 32'h0000_0300;
    for (int s = 0; s < 2; s++)
      for (int t = 0; t < 2; t++)
        for (int o = 0; o < 4; o++)
        begin
          if (t == 1 && o == 3)
            continue;
          @(posedge clk);
          drive(1'b0, 2'(t), s[0], 1'b0, base, 32'(o), 32'h0);
          wait_grant();
          compare("mem_we_o", 32'(mem_we_o), 32'd0);
          release_req();
          @(posedge clk);
          compare("lsu_ready_wb_o", 32'(lsu_ready_wb_o), 32'd0);  // Response still out
          wait_rvalid();
          compare("lsu_ready_wb_o", 32'(lsu_ready_wb_o), 32'd1);
          compare("lsu_rdata_o", lsu_rdata_o,
                  exp_load(read_word(base[31:2]), 2'(t), o, s[0]));
          wait_idle();
          base = base + 32'd8;
        end
    report_test("byte and halfword loads", c0, e0);
  endtask

  task automatic misaligned_loads();
    int c0;
    int e0;
    logic [31:0] base;
    logic [31:0] w0;
    logic [31:0] w1;
    c0 = checks;
    e0 = errors;
    for (int o = 1; o < 4; o++)
    begin
      base = 32'h0000_0500 + 32'(16 * o);
      w0   = read_word(base[31:2]);
      w1   = read_word(base[31:2] + 30'd1);
      @(posedge clk);
      drive(1'b0, DT_WORD, 1'b0, 1'b0, base, 32'(o), 32'h0);
      wait_grant();
      compare("lsu_misaligned_o", 32'(lsu_misaligned_o), 32'd1);
      drive(1'b0, DT_WORD, 1'b0, 1'b1, base + 32'd4, 32'(o), 32'h0);  // Second phase
      wait_grant();
      compare("mem_addr_o", mem_addr_o, base + 32'd4);
      while (!lsu_ready_ex_o)                 // Core holds phase two until EX may advance
        @(posedge clk);
      release_req();
      wait_rvalid();
      compare("lsu_rdata_o", lsu_rdata_o, (w0 >> (8 * o)) | (w1 << (32 - 8 * o)));
      wait_idle();
    end
    report_test("misaligned word loads", c0, e0);
  endtask

  task automatic misaligned_stores();
    int c0;
    int e0;
    int o;
    logic [1:0]  typ;
    logic [31:0] base;
    logic [31:0] wd;
    c0 = checks;
    e0 = errors;
    for (int k = 0; k < 4; k++)
    begin
      typ  = (k < 3) ? DT_WORD : DT_HALF;     // Words at 1..3, then a halfword at 3
      o    = (k < 3) ? k + 1 : 3;
      base = 32'h0000_0600 + 32'(16 * k);
      wd   = $urandom;
      @(posedge clk);
      drive(1'b1, typ, 1'b0, 1'b0, base, 32'(o), wd);
      wait_grant();
      compare("mem_be_o", 32'(mem_be_o), 32'(exp_be(typ, o, 1'b0)));
      compare("mem_wdata_o", mem_wdata_o, rotl_bytes(wd, o));
      drive(1'b1, typ, 1'b0, 1'b1, base + 32'd4, 32'(o), wd);
      wait_grant();
      compare("mem_be_o", 32'(mem_be_o), 32'(exp_be(typ, o, 1'b1)));
      compare("mem_wdata_o", mem_wdata_o, rotl_bytes(wd, o));
      compare("mem_addr_o", mem_addr_o, base + 32'd4);
      while (!lsu_ready_ex_o)
        @(posedge clk);
      release_req();
      wait_idle();
    end
    report_test("misaligned stores", c0, e0);
  endtask

  task automatic back_pressure();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    @(posedge clk);
    mem_gnt_i <= 1'b0;
    drive(1'b0, DT_HALF, 1'b1, 1'b0, 32'h0000_0700, 32'd2, 32'h0);
    repeat (6)
    begin
      @(posedge clk);
      compare("mem_req_o", 32'(mem_req_o), 32'd1);
      compare("lsu_ready_ex_o", 32'(lsu_ready_ex_o), 32'd0);
      compare("lsu_ready_wb_o", 32'(lsu_ready_wb_o), 32'd1);  // Nothing outstanding yet
      compare("busy_o", 32'(busy_o), 32'd1);
    end
    mem_gnt_i <= 1'b1;
    wait_grant();
    release_req();
    wait_rvalid();
    compare("lsu_rdata_o", lsu_rdata_o,
            exp_load(read_word(30'h0000_01c0), DT_HALF, 2, 1'b1));
    wait_idle();
    report_test("back-pressure", c0, e0);
  endtask

  // Core advances on lsu_ready_ex_o; a response delay of two fills both slots
  task automatic random_traffic();
    int c0;
    int e0;
    int issued;
    int o;
    bit          is_ld_q[$];
    logic [31:0] exp_q[$];
    bit          cur_ld;
    logic [1:0]  cur_typ;
    bit          cur_sext;
    logic [31:0] cur_addr;
    logic [31:0] exp_v;
    c0         = checks;
    e0         = errors;
    resp_delay = 2;
    issued     = 0;
    cur_ld     = 1'b0;
    cur_typ    = DT_WORD;
    cur_sext   = 1'b0;
    cur_addr   = '0;
    @(posedge clk);
    while (issued < N_RAND || is_ld_q.size() > 0 || data_req_i)
    begin
      if (issued > 0)
        @(posedge clk);
      if (mem_rvalid_i && is_ld_q.size() > 0)
      begin
        exp_v = exp_q.pop_front();
        if (is_ld_q.pop_front())
          compare("lsu_rdata_o", lsu_rdata_o, exp_v);
      end
      if (issued == 0 || (data_req_i && lsu_ready_ex_o))
      begin
        if (issued > 0)
        begin
          is_ld_q.push_back(cur_ld);          // Current transfer accepted
          exp_q.push_back(exp_load(read_word(cur_addr[31:2]), cur_typ,
                                   int'(cur_addr[1:0]), cur_sext));
        end
        if (issued < N_RAND)
        begin
          cur_ld   = ($urandom % 2) == 0;
          cur_typ  = 2'($urandom % 3);
          cur_sext = 1'($urandom % 2);
          o        = (cur_typ == DT_BYTE) ? int'($urandom % 4) :
                     (cur_typ == DT_HALF) ? int'(2 * ($urandom % 2)) : 0;
          cur_addr = 32'h0000_0400 + 32'(4 * ($urandom % 8)) + 32'(o);
          drive(!cur_ld, cur_typ, cur_sext, 1'b0, cur_addr - 32'(o), 32'(o), $urandom);
          issued++;
        end
        else
          release_req();
      end
    end
    wait_idle();
    resp_delay = 1;
    report_test("random aligned traffic", c0, e0);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////

  initial
  begin
    data_req_i        = 1'b0;
    data_we_i         = 1'b0;
    data_type_i       = DT_WORD;
    data_sign_ext_i   = 1'b0;
    data_misaligned_i = 1'b0;
    prepost_useincr_i = 1'b0;
    operand_a_i       = '0;
    operand_b_i       = '0;
    wdata_i           = '0;
    mem_gnt_i         = 1'b1;
    mem_rvalid_i      = 1'b0;
    mem_rdata_i       = '0;
    resp_delay        = 1;
    cycles            = 0;
    checks            = 0;
    errors            = 0;
    tests             = 0;
    void'($urandom(32'hd7d0_7bfe));
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    aligned_stores();
    byte_half_loads();
    misaligned_loads();
    misaligned_stores();
    back_pressure();
    random_traffic();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule : lsu_tb

`default_nettype wire

/* files.f */
hw/lsu_pkg.sv
hw/lsu_ctrl.sv
hw/lsu_wr_align.sv
hw/lsu_rd_align.sv
hw/lsu_top.sv
tb/tb_clkgen.sv
tb/lsu_sva.sv
tb/lsu_tb.sv

/* Makefile */
# Verilator flow for the load/store unit

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= files.f
BUILD     ?= obj_dir
LOG       ?= sim.log
TSCALE    ?= 1ns/1ps
VFLAGS    ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TSCALE) $(VFLAGS) \
		-f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary --timing --assert --timescale $(TSCALE) $(VFLAGS) \
		-f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
